// File: Makefile
# Verilator flow for the NFU-2 adder tree
#
# make lint    lint the RTL top level
# make sim     build and run the testbench, fail status on a failing run
# make clean   remove build products and the log

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= nfu2_tb
RTL_TOP   ?= nfu2_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard logic/*.sv logic/*.svh dv/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# The log decides the result, the pipe through tee hides the exit status
sim: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/nfu2_tb.sv
// NFU-2 adder tree testbench

`include "nfu2_consts.svh"

module nfu2_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reuse_count  = 4;
    localparam int lanes        = `NFU2_TN;
    localparam int reset_cycles = 4;
    localparam int idle_cycles  = 2;

    // Product patterns
    localparam int pat_zero   = 0;
    localparam int pat_ramp   = 1;
    localparam int pat_ones   = 2;
    localparam int pat_random = 3;

    // Reuse pattern with its own value in every lane and slot
    localparam int pat_lane = 4;

    // DUT ports
    logic                                       clk = 1'b0;
    logic                                       i_reset;
    logic                                       i_valid;
    nfu2_pkg::lane_words_t [`NFU2_TN-1:0]       i_products;
    nfu2_pkg::word_t [`NFU2_TN*reuse_count-1:0] i_reuse;
    nfu2_pkg::lane_sums_t                       i_partial_sum;
    nfu2_pkg::lane_sums_t                       o_results;
    logic                                       o_valid;

    // Stimulus table, one row per test
    string           test_names [$];
    int              product_pat [$];
    nfu2_pkg::word_t partial_base [$];
    int              reuse_pat [$];
    int              gap_cycles [$];

    // Samples in flight, oldest first
    nfu2_pkg::lane_sums_t expected_q [$];
    string                name_q [$];
    int                   due_q [$];

    logic [31:0] lcg_state = 32'h09e5_0c90;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          check_count = 0;
    int          mismatch_count = 0;
    int          other_errors = 0;

    nfu2_top #(
        .reuse_count (reuse_count)
    ) nfu2_top_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_products    (i_products),
        .i_reuse       (i_reuse),
        .i_partial_sum (i_partial_sum),
        .o_results     (o_results),
        .o_valid       (o_valid)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper half of the state has the better randomness
    task automatic next_random(output nfu2_pkg::word_t word);
        lcg_state = lcg_step(lcg_state);
        word = lcg_state[31:16];
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("CHECK FAILED %s %s: expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input int prod, input nfu2_pkg::word_t psum,
                             input int reuse, input int gap);
        test_names.push_back(name);
        product_pat.push_back(prod);
        partial_base.push_back(psum);
        reuse_pat.push_back(reuse);
        gap_cycles.push_back(gap);
    endtask

    task automatic load_table();
        //        name               products    psum base  reuse       gap
        add_entry("zero_all",        pat_zero,   16'h0000,  pat_zero,   2);
        add_entry("ramp_products",   pat_ramp,   16'h0000,  pat_zero,   3);
        add_entry("lane_reuse",      pat_zero,   16'h0100,  pat_lane,   1);
        add_entry("ramp_reuse_psum", pat_ramp,   16'h0123,  pat_lane,   0);
        add_entry("ones_wrap",       pat_ones,   16'hffff,  pat_ones,   0);
        add_entry("random_a",        pat_random, 16'h7fff,  pat_random, 0);
        add_entry("random_b",        pat_random, 16'h8001,  pat_random, 0);
        add_entry("random_c",        pat_random, 16'h4321,  pat_lane,   2);
        add_entry("ones_b2b",        pat_ones,   16'h0000,  pat_random, 0);
        add_entry("ramp_b2b",        pat_ramp,   16'hfffe,  pat_ones,   0);
        add_entry("random_last",     pat_random, 16'h1357,  pat_random, 1);
    endtask

    // Drives one sample and queues the expected lane sums
    // Lane result is the wrapped sum of products, reuse words and partial sum
    task automatic apply_entry(input int idx);
        nfu2_pkg::word_t      word;
        nfu2_pkg::word_t      sum;
        nfu2_pkg::word_t      psum;
        nfu2_pkg::lane_sums_t expected;
        for (int n = 0; n < lanes; n++) begin
            sum = '0;
            for (int k = 0; k < lanes; k++) begin
                case (product_pat[idx])
                    pat_zero: word = '0;
                    pat_ramp: word = 16'(n * lanes + k + 1);
                    pat_ones: word = '1;
                    default:  next_random(word);
                endcase
                i_products[n][k] = word;
                sum = sum + word;
            end
            for (int r = 0; r < reuse_count; r++) begin
                case (reuse_pat[idx])
                    pat_zero: word = '0;
                    pat_lane: word = 16'(n * 272 + r * 4097 + 1);
                    pat_ones: word = '1;
                    default:  next_random(word);
                endcase
                i_reuse[n * reuse_count + r] = word;
                sum = sum + word;
            end
            // Base times lane number keeps each lane distinct
            psum = 16'(32'(partial_base[idx]) * (n + 1));
            i_partial_sum[n] = psum;
            expected[n] = sum + psum;
        end
        i_valid = 1'b1;
        expected_q.push_back(expected);
        name_q.push_back(test_names[idx]);
        // Next rising edge takes the sample
        // Result register loads on the edge after it
        due_q.push_back(cycle_count + 2);
    endtask

    task automatic finish_run();
        $display("Checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Edge counter and watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            other_errors++;
            $display("Timeout: run did not finish within %0d cycles, %0d results missing",
                     timeout_limit, expected_q.size());
            finish_run();
        end
    end

    // Output monitor sampling in the middle of the cycle
    always @(negedge clk) begin : monitor
        nfu2_pkg::lane_sums_t expected;
        string                name;
        int                   due;
        if (cycle_count <= reset_cycles) begin
            if (o_valid !== 1'b0) begin
                other_errors++;
                $display("o_valid is not low during reset at cycle %0d", cycle_count);
            end
        end else if ($isunknown(o_valid)) begin
            other_errors++;
            $display("o_valid is unknown at cycle %0d", cycle_count);
        end else if (o_valid) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("o_valid high at cycle %0d with no sample in flight", cycle_count);
            end else begin
                expected = expected_q.pop_front();
                name = name_q.pop_front();
                due = due_q.pop_front();
                check_value(name, "latency cycle", 32'(due), 32'(cycle_count));
                for (int n = 0; n < lanes; n++) begin
                    check_value(name, $sformatf("lane %0d", n),
                                32'(expected[n]), 32'(o_results[n]));
                end
            end
        end
    end

    initial begin
        int total;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_products = '0;
        i_reuse = '0;
        i_partial_sum = '0;

        load_table();
        total = 0;
        for (int i = 0; i < test_names.size(); i++) begin
            total += gap_cycles[i] + 1;
        end
        // Two cycles of latency and a margin for reset and drain
        timeout_limit = total + 2 + 20;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        // o_valid must stay low through the idle cycles before the first sample
        repeat (idle_cycles) @(negedge clk);

        for (int i = 0; i < test_names.size(); i++) begin
            apply_entry(i);
            @(negedge clk);
            i_valid = 1'b0;
            repeat (gap_cycles[i]) @(negedge clk);
        end

        // Drain the pipeline
        while (expected_q.size() != 0 && cycle_count < timeout_limit) begin
            @(negedge clk);
        end
        if (expected_q.size() != 0) begin
            other_errors++;
            $display("%0d expected results never appeared, first from test %s",
                     expected_q.size(), name_q[0]);
        end

        // A few quiet cycles to catch a stray strobe
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

// File: logic/nfu2_consts.svh
// NFU-2 datapath constants

`ifndef NFU2_CONSTS_SVH
`define NFU2_CONSTS_SVH

// Width of one data word
// Products, partial sums, reuse operands and results share it
`define NFU2_BIT_WIDTH 16

// Output neurons per pass
// Each lane also reduces this many products
`define NFU2_TN 16

// Largest number of reused multiplication results per lane
`define NFU2_REUSE_MAX 4

`endif

// File: logic/nfu2_lane_tree.sv
// NFU-2 lane adder tree

`include "nfu2_consts.svh"

module nfu2_lane_tree (
    // Products of this lane from the multiplier stage
    input  nfu2_pkg::lane_words_t i_products,
    // Wrapped sum of all products
    output nfu2_pkg::word_t       o_sum
);

    // Tree geometry
    // Leaf count must be a power of two
    localparam int leaves = `NFU2_TN;
    localparam int levels = $clog2(leaves);

    // Level lvl holds leaves >> lvl partial sums
    // Level 1 adds product pairs, last level is the root
    // 8 + 4 + 2 + 1 adders for sixteen products
    genvar lvl;
    genvar j;
    generate
        for (lvl = 1; lvl <= levels; lvl++) begin : g_level
            localparam int count = leaves >> lvl;

            // Sums produced by this level
            nfu2_pkg::word_t sum [count];

            for (j = 0; j < count; j++) begin : g_add
                if (lvl == 1) begin : g_first
                    // Neighbouring products 2j and 2j+1
                    assign sum[j] = i_products[2*j] + i_products[2*j+1];
                end else begin : g_inner
                    // Pair of sums from the level below
                    assign sum[j] = g_level[lvl-1].sum[2*j] + g_level[lvl-1].sum[2*j+1];
                end
            end
        end
    endgenerate

    // Root of the tree
    assign o_sum = g_level[levels].sum[0];

endmodule

// File: logic/nfu2_pkg.sv
// NFU-2 shared types

`include "nfu2_consts.svh"

package nfu2_pkg;

    // One data word, two's complement, wraps on overflow
    // Sign is left to the consumer, adds are the same either way
    typedef logic [`NFU2_BIT_WIDTH-1:0] word_t;

    // All products of one lane
    // Word k sits at bits 16k+15 down to 16k
    typedef word_t [`NFU2_TN-1:0] lane_words_t;

    // One word per lane across all lanes
    // Carries tree sums, partial sums and results
    typedef word_t [`NFU2_TN-1:0] lane_sums_t;

endpackage

// File: logic/nfu2_reuse_accum.sv
// NFU-2 reuse and accumulate stage

`include "nfu2_consts.svh"

module nfu2_reuse_accum #(
    // Reused multiplication results per lane, 1 to 4
    parameter int reuse_count = 1
) (
    input  logic                                       clk,
    input  logic                                       i_reset,
    // Sample strobe, same cycle as the products at the tree stage
    input  logic                                       i_valid,
    // Lane n takes words n*reuse_count onward
    input  nfu2_pkg::word_t [`NFU2_TN*reuse_count-1:0] i_reuse,
    // Partial sums from the output buffer, one per lane
    input  nfu2_pkg::lane_sums_t                       i_partial_sum,
    // Registered lane sums from the tree stage
    input  nfu2_pkg::lane_sums_t                       i_tree_sums,
    input  logic                                       i_tree_valid,
    // Final neuron sums, two cycles after the sample
    output nfu2_pkg::lane_sums_t                       o_results,
    output logic                                       o_valid
);

    // Reuse words plus partial sum, before and after the register
    nfu2_pkg::lane_sums_t side_sum;
    nfu2_pkg::lane_sums_t side_sum_q;

    // Strobe travelling alongside side_sum_q
    logic side_valid_q;

    // Side path per lane
    // Reuse words summed first, partial sum added last
    genvar n;
    generate
        for (n = 0; n < `NFU2_TN; n++) begin : g_lane
            nfu2_pkg::word_t reuse_sum;

            always_comb begin
                reuse_sum = '0;
                for (int r = 0; r < reuse_count; r++) begin
                    reuse_sum = reuse_sum + i_reuse[n*reuse_count + r];
                end
            end

            assign side_sum[n] = reuse_sum + i_partial_sum[n];
        end
    endgenerate

    // Cycle 1, runs in parallel with the product trees
    always_ff @(posedge clk) begin
        side_sum_q <= side_sum;
    end

    // Cycle 2, merge add per lane
    // Each lane wraps on its own, no carry between lanes
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < `NFU2_TN; lane++) begin
            o_results[lane] <= i_tree_sums[lane] + side_sum_q[lane];
        end
    end

    // Strobe pipeline, two stages deep
    always_ff @(posedge clk) begin
        if (i_reset) begin
            side_valid_q <= 1'b0;
            o_valid      <= 1'b0;
        end else begin
            side_valid_q <= i_valid;
            o_valid      <= side_valid_q;
        end
    end

    // Both halves of the merge must belong to the same sample
    assert property (@(posedge clk) disable iff (i_reset) i_tree_valid == side_valid_q)
        else $error("tree stage and side path out of step");

    // Reuse width outside the supported range
    assert property (@(posedge clk) reuse_count >= 1 && reuse_count <= `NFU2_REUSE_MAX)
        else $error("reuse_count %0d out of range", reuse_count);

endmodule

// File: logic/nfu2_top.sv
// NFU-2 adder tree top

`include "nfu2_consts.svh"

module nfu2_top #(
    // Reused multiplication results per lane, 1 to 4
    parameter int reuse_count = 1
) (
    input  logic                                       clk,
    input  logic                                       i_reset,
    // One-cycle sample strobe
    input  logic                                       i_valid,
    // Lane n takes products 16n to 16n+15
    input  nfu2_pkg::lane_words_t [`NFU2_TN-1:0]       i_products,
    // Lane n takes reuse words n*reuse_count onward
    input  nfu2_pkg::word_t [`NFU2_TN*reuse_count-1:0] i_reuse,
    // One partial sum per lane
    input  nfu2_pkg::lane_sums_t                       i_partial_sum,
    // One result per lane, two cycles after the sample
    output nfu2_pkg::lane_sums_t                       o_results,
    output logic                                       o_valid
);

    // Tree stage to accumulate stage
    nfu2_pkg::lane_sums_t tree_sums;
    logic                 tree_valid;

    // Producer
    // Sixteen product trees and the first register
    nfu2_tree_stage tree_stage_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_products   (i_products),
        .o_tree_sums  (tree_sums),
        .o_tree_valid (tree_valid)
    );

    // Consumer
    // Side operands enter here directly and are registered
    // in step with the trees, then merged on the second edge
    nfu2_reuse_accum #(
        .reuse_count (reuse_count)
    ) reuse_accum_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_reuse       (i_reuse),
        .i_partial_sum (i_partial_sum),
        .i_tree_sums   (tree_sums),
        .i_tree_valid  (tree_valid),
        .o_results     (o_results),
        .o_valid       (o_valid)
    );

endmodule

// File: logic/nfu2_tree_stage.sv
// NFU-2 product tree stage

`include "nfu2_consts.svh"

module nfu2_tree_stage (
    input  logic                                 clk,
    input  logic                                 i_reset,
    // Sample strobe, one cycle per sample
    input  logic                                 i_valid,
    // Lane n takes products 16n to 16n+15
    input  nfu2_pkg::lane_words_t [`NFU2_TN-1:0] i_products,
    // Registered lane sums, one cycle after the sample
    output nfu2_pkg::lane_sums_t                 o_tree_sums,
    output logic                                 o_tree_valid
);

    // Combinational lane sums straight out of the trees
    nfu2_pkg::lane_sums_t lane_sum;

    // One adder tree per output neuron
    genvar n;
    generate
        for (n = 0; n < `NFU2_TN; n++) begin : g_lane
            nfu2_lane_tree lane_tree_inst (
                .i_products (i_products[n]),
                .o_sum      (lane_sum[n])
            );
        end
    endgenerate

    // Sum register
    // Loads every cycle, the strobe says which cycles matter
    always_ff @(posedge clk) begin
        o_tree_sums <= lane_sum;
    end

    // Strobe follows the sample by one cycle
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_tree_valid <= 1'b0;
        end else begin
            o_tree_valid <= i_valid;
        end
    end

    // No stale strobe may leak out of reset into the accumulate stage
    assert property (@(posedge clk) i_reset |=> !o_tree_valid)
        else $error("tree stage valid high in the cycle after reset");

endmodule

// File: vlog.f
+incdir+logic
logic/nfu2_pkg.sv
logic/nfu2_lane_tree.sv
logic/nfu2_tree_stage.sv
logic/nfu2_reuse_accum.sv
logic/nfu2_top.sv
dv/nfu2_tb.sv
